//--- source/nes_loader_pkg.sv
// Shared constants for the iNES cartridge loader
// Address bases, header layout, mapper flag bit positions, loader states

package nes_loader_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	localparam int ROM_ADDR_W = 22;
	localparam int ROM_DATA_W = 8;
	localparam int FLAGS_W    = 32;
	localparam int PAGE_W     = 8;

	// Memory map of the cartridge image
	localparam logic [ROM_ADDR_W-1:0] PRG_BASE = 22'h000000;
	localparam logic [ROM_ADDR_W-1:0] CHR_BASE = 22'h200000;
	localparam int PRG_PAGE_SHIFT = 14;	// 16 KiB pages
	localparam int CHR_PAGE_SHIFT = 13;	// 8 KiB pages

	// iNES header
	localparam int HDR_LEN   = 16;
	localparam int HDR_IDX_W = $clog2(HDR_LEN);
	localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;	// "NES" then 1A

	//////////////////////////////////////////////////////////////////////
	// Mapper flag word layout
	//////////////////////////////////////////////////////////////////////

	localparam int FLAG_MAPPER_LSB   = 0;
	localparam int FLAG_MAPPER_W     = 8;
	localparam int FLAG_PRG_SIZE_LSB = 8;
	localparam int FLAG_CHR_SIZE_LSB = 11;
	localparam int SIZE_CODE_W       = 3;
	localparam int FLAG_MIRROR       = 14;
	localparam int FLAG_CHR_RAM      = 15;
	localparam int FLAG_FOUR_SCREEN  = 16;
	localparam int FLAG_NES20_LSB    = 17;	// Raw NES 2.0 byte 8
	localparam int FLAG_BATTERY      = 25;
	localparam int FLAG_PRG_RAM_LSB  = 26;
	localparam int FLAG_PRG_RAM_W    = 4;
	localparam int FLAG_PIANO        = 30;
	localparam int FLAG_ZERO         = 31;

	// Five states need three bits
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD_PRG,
		ST_LOAD_CHR,
		ST_DONE,
		ST_ERROR
	} loader_state_t;

endpackage

//--- source/ines_header_if.sv
// Parsed iNES header result, parser to stream loader
// Parser modport drives, loader modport samples

`timescale 1ns/1ps

interface ines_header_if;
	import nes_loader_pkg::*;

	logic              hdr_done;	// One cycle, after the last header byte
	logic              hdr_bad;	// Bad magic or trainer, valid with hdr_done
	logic [PAGE_W-1:0] prg_pages;
	logic [PAGE_W-1:0] chr_pages;

	modport parser (
		output hdr_done,
		output hdr_bad,
		output prg_pages,
		output chr_pages
	);

	modport loader (
		input hdr_done,
		input hdr_bad,
		input prg_pages,
		input chr_pages
	);

endinterface

//--- source/ines_header_parser.sv
// iNES header parser
// Collects the 16 header bytes, checks magic and trainer,
// builds the 32-bit mapper flag word

`timescale 1ns/1ps

module ines_header_parser (
	input  logic                                  clk,
	input  logic                                  reset_nes,
	input  logic [nes_loader_pkg::ROM_DATA_W-1:0] in_data,
	input  logic                                  in_strobe,
	input  logic                                  invert_mirroring,
	output logic [nes_loader_pkg::FLAGS_W-1:0]    mapper_flags,
	ines_header_if.parser                         hdr
);
	import nes_loader_pkg::*;

	logic [ROM_DATA_W-1:0] ines [HDR_LEN];	// Raw header bytes
	logic [HDR_IDX_W-1:0]  byte_cnt;
	logic                  hdr_full;
	logic                  hdr_done_r;

	logic                  is_nes20;
	logic                  is_dirty;
	logic                  piano;
	logic [FLAGS_W-1:0]    flags_word;

	// Page count to size code, 0 or 1 page is code 0
	function automatic logic [SIZE_CODE_W-1:0] size_code(input logic [PAGE_W-1:0] pages);
		logic [SIZE_CODE_W-1:0] code;
		if (pages <= 1)
			code = 3'd0;
		else if (pages <= 2)
			code = 3'd1;
		else if (pages <= 4)
			code = 3'd2;
		else if (pages <= 8)
			code = 3'd3;
		else if (pages <= 16)
			code = 3'd4;
		else if (pages <= 32)
			code = 3'd5;
		else if (pages <= 64)
			code = 3'd6;
		else
			code = 3'd7;
		return code;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Byte collection
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			byte_cnt   <= '0;
			hdr_full   <= 1'b0;
			hdr_done_r <= 1'b0;
		end else begin
			hdr_done_r <= 1'b0;
			if (in_strobe && !hdr_full) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == HDR_IDX_W'(HDR_LEN - 1)) begin
					hdr_full   <= 1'b1;	// Payload bytes from here on
					hdr_done_r <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_strobe && !hdr_full)
			ines[byte_cnt] <= in_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	assign is_nes20 = (ines[7][3:2] == 2'b10);
	// Junk in bytes 9..15 of an old header spoils the upper mapper nibble
	assign is_dirty = !is_nes20 &&
		(|{ines[9], ines[10], ines[11], ines[12], ines[13], ines[14], ines[15]});
	assign piano    = is_nes20 && (ines[15][5:0] == 6'h19);

	always_comb begin
		flags_word = '0;
		flags_word[FLAG_MAPPER_LSB +: FLAG_MAPPER_W] =
			{(is_dirty ? 4'h0 : ines[7][7:4]), ines[6][7:4]};
		flags_word[FLAG_PRG_SIZE_LSB +: SIZE_CODE_W] = size_code(ines[4]);
		flags_word[FLAG_CHR_SIZE_LSB +: SIZE_CODE_W] = size_code(ines[5]);
		flags_word[FLAG_MIRROR]      = ines[6][0] ^ invert_mirroring;
		flags_word[FLAG_CHR_RAM]     = (ines[5] == '0);
		flags_word[FLAG_FOUR_SCREEN] = ines[6][3];
		flags_word[FLAG_NES20_LSB +: ROM_DATA_W] = is_nes20 ? ines[8] : '0;
		flags_word[FLAG_BATTERY]     = ines[6][1];
		flags_word[FLAG_PRG_RAM_LSB +: FLAG_PRG_RAM_W] = is_nes20 ? ines[10][3:0] : 4'h0;
		flags_word[FLAG_PIANO]       = piano;
		flags_word[FLAG_ZERO]        = 1'b0;
	end

	assign mapper_flags  = hdr_full ? flags_word : '0;	// Zero until header complete

	assign hdr.hdr_done  = hdr_done_r;
	assign hdr.hdr_bad   = ({ines[0], ines[1], ines[2], ines[3]} != INES_MAGIC) || ines[6][2];
	assign hdr.prg_pages = ines[4];
	assign hdr.chr_pages = ines[5];

	// Only one header per image
	a_single_hdr_done: assert property (@(posedge clk) disable iff (reset_nes)
		hdr.hdr_done |=> (!hdr.hdr_done until reset_nes))
		else $error("hdr_done seen twice without reset");

endmodule

//--- source/rom_stream_loader.sv
// PRG and CHR payload sequencer
// FSM turning each payload strobe into a memory write request

`timescale 1ns/1ps

module rom_stream_loader (
	input  logic                                  clk,
	input  logic                                  reset_nes,
	input  logic [nes_loader_pkg::ROM_DATA_W-1:0] in_data,
	input  logic                                  in_strobe,
	ines_header_if.loader                         hdr,
	output logic                                  wr_req,
	output logic [nes_loader_pkg::ROM_ADDR_W-1:0] wr_addr,
	output logic [nes_loader_pkg::ROM_DATA_W-1:0] wr_data,
	output logic                                  busy,
	output logic                                  done,
	output logic                                  error
);
	import nes_loader_pkg::*;

	loader_state_t         state;
	logic [ROM_ADDR_W-1:0] addr_cnt;
	logic [ROM_ADDR_W-1:0] bytes_left;
	logic [ROM_ADDR_W-1:0] prg_len;
	logic [ROM_ADDR_W-1:0] chr_len;
	logic                  loading;
	logic                  last_byte;

	assign prg_len   = ROM_ADDR_W'(hdr.prg_pages) << PRG_PAGE_SHIFT;
	assign chr_len   = ROM_ADDR_W'(hdr.chr_pages) << CHR_PAGE_SHIFT;
	assign loading   = (state == ST_LOAD_PRG) || (state == ST_LOAD_CHR);
	assign last_byte = (bytes_left == ROM_ADDR_W'(1));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= ST_IDLE;
			addr_cnt   <= PRG_BASE;
			bytes_left <= '0;
			wr_req     <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			wr_req <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (hdr.hdr_done) begin
						if (hdr.hdr_bad) begin
							state <= ST_ERROR;
							done  <= 1'b1;
							error <= 1'b1;
						end else begin
							busy <= 1'b1;
							if (prg_len != '0) begin
								state      <= ST_LOAD_PRG;
								addr_cnt   <= PRG_BASE;
								bytes_left <= prg_len;
							end else if (chr_len != '0) begin
								state      <= ST_LOAD_CHR;	// No PRG at all
								addr_cnt   <= CHR_BASE;
								bytes_left <= chr_len;
							end else begin
								state <= ST_DONE;
							end
						end
					end
				end
				ST_LOAD_PRG, ST_LOAD_CHR: begin
					if (in_strobe) begin
						wr_req     <= 1'b1;
						addr_cnt   <= addr_cnt + 1'b1;
						bytes_left <= bytes_left - 1'b1;
						if (last_byte) begin
							// Switch bank on the last byte, no idle cycle
							if (state == ST_LOAD_PRG && chr_len != '0) begin
								state      <= ST_LOAD_CHR;
								addr_cnt   <= CHR_BASE;
								bytes_left <= chr_len;
							end else begin
								state <= ST_DONE;
							end
						end
					end
				end
				ST_DONE: begin
					busy <= 1'b0;
					done <= 1'b1;	// Held until reset
				end
				default: begin
					// Error is terminal, flags already set
				end
			endcase
		end
	end

	// Request payload
	always_ff @(posedge clk) begin
		if (loading && in_strobe) begin
			wr_addr <= addr_cnt;
			wr_data <= in_data;
		end
	end

	a_req_in_load: assert property (@(posedge clk) disable iff (reset_nes)
		wr_req |-> ($past(state) inside {ST_LOAD_PRG, ST_LOAD_CHR}))
		else $error("wr_req outside PRG or CHR load");

	// The host leaves a gap after the last header byte
	a_no_strobe_on_hdr: assert property (@(posedge clk) disable iff (reset_nes)
		hdr.hdr_done |-> !in_strobe)
		else $error("payload strobe in the hdr_done cycle");

endmodule

//--- source/loader_write_buffer.sv
// Single-entry write holding buffer
// Aligns a loader write to the memory slot and drives ioctl_wait

`timescale 1ns/1ps

module loader_write_buffer (
	input  logic                                  clk,
	input  logic                                  reset_nes,
	input  logic                                  wr_req,
	input  logic [nes_loader_pkg::ROM_ADDR_W-1:0] wr_addr,
	input  logic [nes_loader_pkg::ROM_DATA_W-1:0] wr_data,
	input  logic                                  mem_slot,
	output logic [nes_loader_pkg::ROM_ADDR_W-1:0] mem_addr,
	output logic [nes_loader_pkg::ROM_DATA_W-1:0] mem_data,
	output logic                                  mem_write,
	output logic                                  ioctl_wait
);
	import nes_loader_pkg::*;

	logic pending;	// A write waits for its slot

	//////////////////////////////////////////////////////////////////////
	// Pending flag and write strobe
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending   <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			mem_write <= 1'b0;
			if (wr_req) begin
				pending <= 1'b1;
			end else if (pending && mem_slot) begin
				mem_write <= 1'b1;	// Lands in the cycle after the slot
				pending   <= 1'b0;
			end
		end
	end

	// Held address and byte
	always_ff @(posedge clk) begin
		if (wr_req) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

	// Host stalls for as long as a write is held
	assign ioctl_wait = pending;

	a_no_overrun: assert property (@(posedge clk) disable iff (reset_nes)
		pending |-> !wr_req)
		else $error("wr_req while a write is still pending");

endmodule

//--- source/nes_rom_loader.sv
// NES cartridge image loader, top level
// Header parser, payload sequencer and write buffer in a chain

`timescale 1ns/1ps

module nes_rom_loader (
	input  logic                                  clk,
	input  logic                                  reset_nes,
	input  logic                                  downloading,
	input  logic [nes_loader_pkg::ROM_DATA_W-1:0] in_data,
	input  logic                                  in_strobe,
	input  logic                                  invert_mirroring,
	input  logic                                  mem_slot,
	output logic [nes_loader_pkg::ROM_ADDR_W-1:0] mem_addr,
	output logic [nes_loader_pkg::ROM_DATA_W-1:0] mem_data,
	output logic                                  mem_write,
	output logic                                  ioctl_wait,
	output logic [nes_loader_pkg::FLAGS_W-1:0]    mapper_flags,
	output logic                                  busy,
	output logic                                  done,
	output logic                                  error
);
	import nes_loader_pkg::*;

	logic                  byte_strobe;
	logic                  wr_req;
	logic [ROM_ADDR_W-1:0] wr_addr;
	logic [ROM_DATA_W-1:0] wr_data;

	// Stray strobes outside a download are dropped
	assign byte_strobe = in_strobe && downloading;

	ines_header_if u_hdr_if ();

	ines_header_parser u_header_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.in_data          (in_data),
		.in_strobe        (byte_strobe),
		.invert_mirroring (invert_mirroring),
		.mapper_flags     (mapper_flags),
		.hdr              (u_hdr_if)
	);

	rom_stream_loader u_stream_loader (
		.clk       (clk),
		.reset_nes (reset_nes),
		.in_data   (in_data),
		.in_strobe (byte_strobe),
		.hdr       (u_hdr_if),
		.wr_req    (wr_req),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.busy      (busy),
		.done      (done),
		.error     (error)
	);

	loader_write_buffer u_write_buffer (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.mem_slot   (mem_slot),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.mem_write  (mem_write),
		.ioctl_wait (ioctl_wait)
	);

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock and reset source
// 10 ns clock, reset held for two cycles at start, extra reset on request

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 5,
	parameter int RESET_CYCLES   = 2
) (
	input  logic reset_req,	// Extra reset from the test sequence
	output logic clk,
	output logic reset_nes
);
	logic por;	// Power-on reset

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	initial begin
		por = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 por = 1'b0;
	end

	assign reset_nes = por || reset_req;

endmodule

//--- verification/tb_nes_rom_loader.sv
// Testbench for the iNES cartridge loader
// Header cases from a pattern file, random payload, random memory slot,
// write monitor with expected address and byte sequence

`timescale 1ns/1ps

module tb_nes_rom_loader;
	import nes_loader_pkg::*;

	localparam int NUM_CASES   = 7;
	localparam int CASE_WORDS  = 19;	// 16 header bytes, invert, error, flags
	localparam int MAX_PAYLOAD = 40960;
	localparam int WAIT_LIMIT  = 200;
	localparam int SEED        = 78852;

	logic                  clk;
	logic                  reset_nes;
	logic                  reset_req;
	logic                  downloading;
	logic [ROM_DATA_W-1:0] in_data;
	logic                  in_strobe;
	logic                  invert_mirroring;
	logic                  mem_slot;
	logic [ROM_ADDR_W-1:0] mem_addr;
	logic [ROM_DATA_W-1:0] mem_data;
	logic                  mem_write;
	logic                  ioctl_wait;
	logic [FLAGS_W-1:0]    mapper_flags;
	logic                  busy;
	logic                  done;
	logic                  error;

	logic [31:0]           patterns [0:NUM_CASES*CASE_WORDS-1];
	logic [ROM_DATA_W-1:0] payload [0:MAX_PAYLOAD-1];
	integer                seed = SEED;
	integer                slot_seed = SEED ^ 32'h0000_5A5A;	// Own stream for the slot
	int                    slot_gap = 0;
	int                    prg_len;
	int                    chr_len;
	int                    exp_total;
	int                    write_count;

	tb_clock_gen u_clock_gen (
		.reset_req (reset_req),
		.clk       (clk),
		.reset_nes (reset_nes)
	);

	nes_rom_loader u_nes_rom_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.in_data          (in_data),
		.in_strobe        (in_strobe),
		.invert_mirroring (invert_mirroring),
		.mem_slot         (mem_slot),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.ioctl_wait       (ioctl_wait),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected)
			fail_run($sformatf("Mismatch at %0t ns: %s, got 'h%0h, expected 'h%0h",
				$time, what, actual, expected));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic advance_with_limit(ref int cycles, input string what);
		next_cycle();
		cycles++;
		if (cycles > WAIT_LIMIT)
			fail_run({"Timeout while waiting for ", what});
	endtask

	// One byte, only while the loader is not stalling
	task automatic send_byte(input logic [ROM_DATA_W-1:0] value);
		int cycles;
		cycles = 0;
		while (ioctl_wait !== 1'b0)
			advance_with_limit(cycles, "ioctl_wait to fall");
		in_data   = value;
		in_strobe = 1'b1;
		next_cycle();
		in_strobe = 1'b0;
	endtask

	task automatic reset_dut();
		reset_req = 1'b1;
		repeat (2) next_cycle();
		reset_req = 1'b0;
	endtask

	task automatic check_idle(input string when);
		check(busy, 1'b0, {when, ": busy"});
		check(done, 1'b0, {when, ": done"});
		check(error, 1'b0, {when, ": error"});
		check(mem_write, 1'b0, {when, ": mem_write"});
		check(ioctl_wait, 1'b0, {when, ": ioctl_wait"});
		check(mapper_flags, '0, {when, ": mapper_flags"});
	endtask

	// PRG bytes from 0, CHR bytes from the CHR base
	function automatic logic [ROM_ADDR_W-1:0] expected_addr(input int idx);
		if (idx < prg_len)
			return PRG_BASE + ROM_ADDR_W'(idx);
		else
			return CHR_BASE + ROM_ADDR_W'(idx - prg_len);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Memory slot and write monitor
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		integer rnd_slot;
		#1;
		if (slot_gap == 0) begin
			mem_slot = 1'b1;
			rnd_slot = $random(slot_seed);
			slot_gap = int'($unsigned(rnd_slot) % 6);	// Next pulse 1 to 6 cycles on
		end else begin
			mem_slot = 1'b0;
			slot_gap--;
		end
	end

	always @(negedge clk) begin
		if (mem_write === 1'b1) begin
			if (write_count >= exp_total) begin
				fail_run($sformatf("Unexpected memory write at address 'h%0h", mem_addr));
			end else begin
				check(mem_addr, expected_addr(write_count),
					$sformatf("address of write %0d", write_count));
				check(mem_data, payload[write_count],
					$sformatf("data of write %0d", write_count));
				check(ioctl_wait, 1'b0,
					$sformatf("ioctl_wait during write %0d", write_count));
				write_count++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int     base;
		int     cycles;
		integer rnd;
		logic   exp_error;
		logic [FLAGS_W-1:0] exp_flags;

		downloading      = 1'b0;
		in_data          = '0;
		in_strobe        = 1'b0;
		invert_mirroring = 1'b0;
		mem_slot         = 1'b0;
		reset_req        = 1'b0;
		write_count      = 0;
		exp_total        = 0;
		prg_len          = 0;
		chr_len          = 0;

		$readmemh("verification/rom_patterns.hex", patterns);
		if ($isunknown(patterns[NUM_CASES*CASE_WORDS-1]))
			fail_run("Pattern file is missing or has too few entries");

		cycles = 0;
		while (reset_nes !== 1'b0)
			advance_with_limit(cycles, "power-on reset to end");
		check_idle("after power-on reset");

		for (int c = 0; c < NUM_CASES; c++) begin
			base = c * CASE_WORDS;
			reset_dut();
			check_idle($sformatf("case %0d after reset", c));

			invert_mirroring = patterns[base+16][0];
			exp_error        = patterns[base+17][0];
			exp_flags        = patterns[base+18];
			prg_len          = int'(patterns[base+4][7:0]) << PRG_PAGE_SHIFT;
			chr_len          = int'(patterns[base+5][7:0]) << CHR_PAGE_SHIFT;
			exp_total        = exp_error ? 0 : prg_len + chr_len;
			write_count      = 0;
			if (exp_total > MAX_PAYLOAD)
				fail_run($sformatf("Case %0d image is larger than the payload buffer", c));
			for (int i = 0; i < exp_total; i++) begin
				rnd        = $random(seed);
				payload[i] = rnd[7:0];
			end

			// Header, with a gap after each byte
			downloading = 1'b1;
			for (int i = 0; i < HDR_LEN; i++) begin
				send_byte(patterns[base+i][7:0]);
				next_cycle();
			end
			cycles = 0;
			while (busy !== 1'b1 && done !== 1'b1)
				advance_with_limit(cycles, $sformatf("header result in case %0d", c));
			check(mapper_flags, exp_flags, $sformatf("case %0d mapper_flags", c));
			check(error, exp_error, $sformatf("case %0d error after header", c));

			if (exp_error) begin
				check(done, 1'b1, $sformatf("case %0d done on rejected image", c));
				check(busy, 1'b0, $sformatf("case %0d busy on rejected image", c));
				for (int i = 0; i < 4; i++)
					send_byte(8'hA5);	// Must be ignored
				repeat (8) next_cycle();
				check(write_count, 0, $sformatf("case %0d writes of rejected image", c));
			end else begin
				for (int i = 0; i < exp_total; i++) begin
					send_byte(payload[i]);
					next_cycle();
					// Request is held, host must be stalled
					check(ioctl_wait, 1'b1,
						$sformatf("ioctl_wait after byte %0d in case %0d", i, c));
					cycles = 0;
					while (write_count != i + 1)
						advance_with_limit(cycles,
							$sformatf("memory write of byte %0d in case %0d", i, c));
				end
				cycles = 0;
				while (done !== 1'b1 || ioctl_wait !== 1'b0)
					advance_with_limit(cycles, $sformatf("done in case %0d", c));
				check(error, 1'b0, $sformatf("case %0d error at end", c));
				check(busy, 1'b0, $sformatf("case %0d busy at end", c));
				check(write_count, exp_total, $sformatf("case %0d write count", c));
				if (chr_len == 0) begin
					check(mapper_flags[FLAG_CHR_RAM], 1'b1, $sformatf("case %0d CHR RAM flag", c));
				end
			end

			downloading      = 1'b0;
			in_data          = '0;
			invert_mirroring = 1'b0;
			next_cycle();
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- verification/rom_patterns.hex
// One case per line: header bytes 0..15, invert_mirroring, expected error,
// expected mapper_flags (32 bits)
// Plain iNES, mapper 41, mirroring and battery
4E 45 53 1A 01 01 13 40 00 00 00 00 00 00 00 00 0 0 02004041
// Dirty header, upper mapper nibble dropped
4E 45 53 1A 01 01 20 30 00 00 00 00 00 44 69 72 0 0 00000002
// NES 2.0 with byte 8, PRG RAM shift 7 and piano
4E 45 53 1A 02 01 41 08 10 00 07 00 00 00 00 19 0 0 5C204104
// Four-screen, mirroring inverted by the host
4E 45 53 1A 01 01 09 00 00 00 00 00 00 00 00 00 1 0 00010000
// No CHR pages, CHR RAM
4E 45 53 1A 01 00 00 00 00 00 00 00 00 00 00 00 0 0 00008000
// Bad magic
4E 45 53 00 05 03 10 00 00 00 00 00 00 00 00 00 0 1 00001301
// Trainer present, large page counts
4E 45 53 1A 80 10 04 00 00 00 00 00 00 00 00 00 0 1 00002700

//--- tb.f
source/nes_loader_pkg.sv
source/ines_header_if.sv
source/ines_header_parser.sv
source/rom_stream_loader.sv
source/loader_write_buffer.sv
source/nes_rom_loader.sv
verification/tb_clock_gen.sv
verification/tb_nes_rom_loader.sv

//--- Bender.yml
package:
  name: nes_rom_loader

sources:
  - files:
      - source/nes_loader_pkg.sv
      - source/ines_header_if.sv
      - source/ines_header_parser.sv
      - source/rom_stream_loader.sv
      - source/loader_write_buffer.sv
      - source/nes_rom_loader.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_nes_rom_loader.sv
